//--- hdl/scsiDmaPkg.sv
// SCSI DMA shared definitions
package scsiDmaPkg;

    localparam int fifoDepth = 8;          // Longword entries
    localparam int fifoPtrW  = 3;          // Next-in / next-out width
    localparam int fifoCntW  = 4;          // Holds 0 to fifoDepth
    localparam int byteIdxW  = 2;          // Byte pointer width

    // One FIFO entry, seen as a longword by the host and as bytes by the SCSI side
    typedef union packed {
        logic [31:0]     longWord;         // Host view
        logic [0:3][7:0] byteLane;         // SCSI view, lane 0 is the MSB
    } fifoWord_u;

    typedef enum logic [2:0] {
        idle,                              // Waiting for CPU or DREQ
        cpuAccess,                         // Chip selected for register cycle
        cpuWait,                           // Terminate and wait for strobe to end
        dmaRead,                           // Byte from chip into FIFO
        dmaWrite,                          // Byte from FIFO to chip
        byteDone                           // Second DACK cycle, advance pointers
    } xferState_e;

endpackage

//--- hdl/scsiTransferFsm.sv
// SCSI transfer state machine
`timescale 1ns/1ps

module scsiTransferFsm (
    input  logic CLK135,                   // Core clock
    input  logic AS_,                      // Async reset, active high
    input  logic cpuReqSync_i,             // Synced CPU register request
    input  logic cpuRw_i,                  // 1 read, 0 write
    input  logic dreqNSync_i,              // Synced chip DMA request, active low
    input  logic dmaDir_i,                 // 0 SCSI to FIFO, 1 FIFO to SCSI
    input  logic fifoFull_i,
    input  logic fifoEmpty_i,
    input  logic boEq3_i,                  // Current byte is last of longword
    input  logic incReqPending_i,          // Count increment not yet acked
    input  logic decReqPending_i,          // Count decrement not yet acked
    output logic cs_o,                     // Chip select
    output logic re_o,                     // Chip read
    output logic we_o,                     // Chip write
    output logic dack_o,                   // DMA acknowledge
    output logic incBo_o,                  // Advance byte pointer
    output logic incNi_o,                  // Advance next-in
    output logic incNo_o,                  // Advance next-out
    output logic s2f_o,                    // SCSI to FIFO path
    output logic f2s_o,                    // FIFO to SCSI path
    output logic cpu2s_o,                  // CPU to SCSI path
    output logic s2cpu_o,                  // SCSI to CPU path
    output logic setDsack_o                // Latch data and end CPU cycle
);

    scsiDmaPkg::xferState_e state;
    scsiDmaPkg::xferState_e nextState;
    logic dmaReady;                        // Room or data for another byte
    logic cpuCycle;
    logic dmaCycle;

    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            state <= scsiDmaPkg::idle;
        end else begin
            state <= nextState;
        end
    end

    // Full or empty FIFO, or a count update still pending, holds off DREQ
    assign dmaReady = dmaDir_i ? (!fifoEmpty_i && !decReqPending_i)
                               : (!fifoFull_i && !incReqPending_i);

    always_comb begin
        nextState = state;
        case (state)
            scsiDmaPkg::idle: begin
                if (cpuReqSync_i) begin     // CPU wins over DMA
                    nextState = scsiDmaPkg::cpuAccess;
                end else if (!dreqNSync_i && dmaReady) begin
                    nextState = dmaDir_i ? scsiDmaPkg::dmaWrite : scsiDmaPkg::dmaRead;
                end
            end
            scsiDmaPkg::cpuAccess: nextState = scsiDmaPkg::cpuWait;
            scsiDmaPkg::cpuWait: begin
                if (!cpuReqSync_i) begin    // Host has ended the cycle
                    nextState = scsiDmaPkg::idle;
                end
            end
            scsiDmaPkg::dmaRead:  nextState = scsiDmaPkg::byteDone;
            scsiDmaPkg::dmaWrite: nextState = scsiDmaPkg::byteDone;
            default:              nextState = scsiDmaPkg::idle;
        endcase
    end

    assign cpuCycle = (state == scsiDmaPkg::cpuAccess) || (state == scsiDmaPkg::cpuWait);
    assign dmaCycle = (state == scsiDmaPkg::dmaRead) || (state == scsiDmaPkg::dmaWrite)
                   || (state == scsiDmaPkg::byteDone);

    assign cs_o       = cpuCycle;
    assign re_o       = (cpuCycle && cpuRw_i) || (dmaCycle && !dmaDir_i);
    assign we_o       = (cpuCycle && !cpuRw_i) || (dmaCycle && dmaDir_i);
    assign dack_o     = dmaCycle;                      // Two cycles per byte
    assign incBo_o    = state == scsiDmaPkg::byteDone;
    assign incNi_o    = incBo_o && !dmaDir_i && boEq3_i; // Longword filled
    assign incNo_o    = incBo_o && dmaDir_i && boEq3_i;  // Longword drained
    assign s2f_o      = dmaCycle && !dmaDir_i;
    assign f2s_o      = dmaCycle && dmaDir_i;
    assign cpu2s_o    = cpuCycle && !cpuRw_i;
    assign s2cpu_o    = cpuCycle && cpuRw_i;
    assign setDsack_o = state == scsiDmaPkg::cpuWait;

endmodule

//--- hdl/scsiSequencer.sv
// SCSI sequencer
`timescale 1ns/1ps

module scsiSequencer (
    input  logic CLK135,
    input  logic AS_,
    input  logic cpuReq_i,                 // CPU register request
    input  logic cpuStrobe_i,              // CPU address strobe
    input  logic cpuRw_i,
    input  logic dmaDir_i,
    input  logic dreqN_i,                  // Chip DMA request, active low
    input  logic fifoFull_i,
    input  logic fifoEmpty_i,
    input  logic boEq3_i,
    input  logic incFifo_i,                // Ack of count increment
    input  logic decFifo_i,                // Ack of count decrement
    output logic scsiCs_o,
    output logic scsiRe_o,
    output logic scsiWe_o,
    output logic scsiDack_o,
    output logic lByteN_o,                 // Load byte into FIFO, active low
    output logic incBo_o,
    output logic incNi_o,
    output logic incNo_o,
    output logic s2f_o,
    output logic f2s_o,
    output logic cpu2s_o,
    output logic s2cpu_o,
    output logic fifoIncReq_o,             // Pending count increment
    output logic fifoDecReq_o,             // Pending count decrement
    output logic ls2Cpu_o                  // Low latches data and ends CPU cycle
);

    logic cCpuReq;                         // Synced inputs
    logic cDreqN;
    logic cs, re, we, dack, incBo, incNi, incNo;
    logic s2f, f2s, cpu2s, s2cpu, setDsack;
    logic setDsackQ;

    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            cCpuReq <= 1'b0;
            cDreqN  <= 1'b1;
        end else begin
            cCpuReq <= cpuReq_i;
            cDreqN  <= dreqN_i;
        end
    end

    scsiTransferFsm i_fsm (
        .CLK135          (CLK135),
        .AS_             (AS_),
        .cpuReqSync_i    (cCpuReq),
        .cpuRw_i         (cpuRw_i),
        .dreqNSync_i     (cDreqN),
        .dmaDir_i        (dmaDir_i),
        .fifoFull_i      (fifoFull_i),
        .fifoEmpty_i     (fifoEmpty_i),
        .boEq3_i         (boEq3_i),
        .incReqPending_i (fifoIncReq_o),
        .decReqPending_i (fifoDecReq_o),
        .cs_o            (cs),
        .re_o            (re),
        .we_o            (we),
        .dack_o          (dack),
        .incBo_o         (incBo),
        .incNi_o         (incNi),
        .incNo_o         (incNo),
        .s2f_o           (s2f),
        .f2s_o           (f2s),
        .cpu2s_o         (cpu2s),
        .s2cpu_o         (s2cpu),
        .setDsack_o      (setDsack)
    );

    // Registered strobes to the chip and FIFO
    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            {scsiCs_o, scsiRe_o, scsiWe_o, scsiDack_o} <= '0;
            {incBo_o, incNi_o, incNo_o, setDsackQ}     <= '0;
            {s2f_o, f2s_o, cpu2s_o, s2cpu_o}           <= '0;
        end else begin
            {scsiCs_o, scsiRe_o, scsiWe_o, scsiDack_o} <= {cs, re, we, dack};
            {incBo_o, incNi_o, incNo_o, setDsackQ}     <= {incBo, incNi, incNo, setDsack};
            {s2f_o, f2s_o, cpu2s_o, s2cpu_o}           <= {s2f, f2s, cpu2s, s2cpu};
        end
    end

    // Count requests, set from the FSM so they are visible before the next byte
    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            fifoIncReq_o <= 1'b0;
            fifoDecReq_o <= 1'b0;
        end else begin
            if (incFifo_i)   fifoIncReq_o <= 1'b0; // Host side took it
            else if (incNi)  fifoIncReq_o <= 1'b1;
            if (decFifo_i)   fifoDecReq_o <= 1'b0;
            else if (incNo)  fifoDecReq_o <= 1'b1;
        end
    end

    // Cycle termination, released only when the strobe goes away
    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            ls2Cpu_o <= 1'b1;
        end else if (!cpuStrobe_i) begin
            ls2Cpu_o <= 1'b1;
        end else if (setDsackQ) begin
            ls2Cpu_o <= 1'b0;
        end
    end

    assign lByteN_o = !(scsiDack_o && scsiRe_o);

endmodule

//--- hdl/dmaFifo.sv
// Eight longword DMA FIFO
`timescale 1ns/1ps

module dmaFifo (
    input  logic                  CLK135,
    input  logic                  AS_,
    input  logic [7:0]            scsiByte_i,  // Byte from chip
    input  logic                  lByte_i,     // Write byte lane
    input  logic                  incBo_i,
    input  logic                  incNi_i,
    input  logic                  incNo_i,
    input  logic                  hostPush_i,
    input  logic                  hostPop_i,
    input  scsiDmaPkg::fifoWord_u hostWord_i,
    input  logic                  incFifo_i,   // Count up
    input  logic                  decFifo_i,   // Count down
    output logic [7:0]            scsiByte_o,  // Byte to chip
    output scsiDmaPkg::fifoWord_u hostWord_o,
    output logic                  boEq3_o,
    output logic                  full_o,
    output logic                  empty_o
);

    scsiDmaPkg::fifoWord_u mem [scsiDmaPkg::fifoDepth];
    logic [scsiDmaPkg::fifoPtrW-1:0] nextIn;     // Written by SCSI or host, by direction
    logic [scsiDmaPkg::fifoPtrW-1:0] nextOut;    // Read by host or SCSI
    logic [scsiDmaPkg::byteIdxW-1:0] bytePtr;    // Lane within the SCSI side entry
    logic [scsiDmaPkg::fifoCntW-1:0] count;      // Completed longwords

    always_ff @(posedge CLK135) begin
        if (hostPush_i) begin
            mem[nextIn] <= hostWord_i;
        end else if (lByte_i) begin
            mem[nextIn].byteLane[bytePtr] <= scsiByte_i;
        end
    end

    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            nextIn  <= '0;
            nextOut <= '0;
            bytePtr <= '0;
        end else begin
            if (incNi_i || hostPush_i) nextIn  <= nextIn + 1'b1;
            if (incNo_i || hostPop_i)  nextOut <= nextOut + 1'b1;
            if (incBo_i)               bytePtr <= bytePtr + 1'b1; // Wraps after lane 3
        end
    end

    // Only the host bus FSM moves the count
    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            count <= '0;
        end else begin
            case ({incFifo_i, decFifo_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign scsiByte_o = mem[nextOut].byteLane[bytePtr];
    assign hostWord_o = mem[nextOut];
    assign boEq3_o    = &bytePtr;
    assign full_o     = count[scsiDmaPkg::fifoCntW-1]; // Count of eight
    assign empty_o    = count == '0;

endmodule

//--- hdl/hostBusFsm.sv
// Host longword port
`timescale 1ns/1ps

module hostBusFsm (
    input  logic                  CLK135,
    input  logic                  AS_,
    input  logic                  hostWrite_i,
    input  logic                  hostRead_i,
    input  logic [31:0]           hostWData_i,
    input  logic                  fifoIncReq_i,  // Sequencer filled a longword
    input  logic                  fifoDecReq_i,  // Sequencer drained a longword
    input  logic                  fifoFull_i,
    input  logic                  fifoEmpty_i,
    input  scsiDmaPkg::fifoWord_u fifoWord_i,
    output logic                  hostPush_o,
    output logic                  hostPop_o,
    output scsiDmaPkg::fifoWord_u fifoWord_o,
    output logic                  incFifo_o,
    output logic                  decFifo_o,
    output logic [31:0]           hostRData_o,
    output logic                  hostRValid_o,
    output logic                  hostFull_o,
    output logic                  hostEmpty_o
);

    logic hostBusy;                              // Own op uses this cycle's count slot

    assign hostPush_o = hostWrite_i && !fifoFull_i;
    assign hostPop_o  = hostRead_i && !fifoEmpty_i && !hostPush_o;
    assign hostBusy   = hostPush_o || hostPop_o;

    // One count update per cycle, host ops first, then increment, then decrement
    assign incFifo_o = hostPush_o || (fifoIncReq_i && !hostBusy);
    assign decFifo_o = hostPop_o || (fifoDecReq_i && !hostBusy && !fifoIncReq_i);

    assign fifoWord_o.longWord = hostWData_i;

    always_ff @(posedge CLK135) begin
        if (hostPop_o) begin
            hostRData_o <= fifoWord_i.longWord;
        end
    end

    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            hostRValid_o <= 1'b0;
        end else begin
            hostRValid_o <= hostPop_o;       // Data valid one cycle after pop
        end
    end

    assign hostFull_o  = fifoFull_i;
    assign hostEmpty_o = fifoEmpty_i;

endmodule

//--- hdl/scsiDmaTop.sv
// SCSI DMA controller top
`timescale 1ns/1ps

module scsiDmaTop (
    input  logic        CLK135,
    input  logic        AS_,
    input  logic        cpuReq_i,
    input  logic        cpuStrobe_i,
    input  logic        cpuRw_i,
    input  logic [7:0]  cpuWData_i,
    input  logic        hostDir_i,       // 0 SCSI to FIFO, 1 FIFO to SCSI
    input  logic        dreqN_i,
    input  logic [7:0]  scsiData_i,
    input  logic        hostWrite_i,
    input  logic [31:0] hostWData_i,
    input  logic        hostRead_i,
    output logic        ls2Cpu_o,
    output logic [7:0]  cpuData_o,
    output logic        scsiCs_o,
    output logic        scsiRe_o,
    output logic        scsiWe_o,
    output logic        scsiDack_o,
    output logic        lByteN_o,
    output logic [7:0]  scsiData_o,
    output logic        hostFull_o,
    output logic        hostEmpty_o,
    output logic [31:0] hostRData_o,
    output logic        hostRValid_o
);

    logic fifoFull, fifoEmpty, boEq3, incFifo, decFifo;
    logic incBo, incNi, incNo, s2f, f2s, cpu2s, s2cpu;
    logic fifoIncReq, fifoDecReq, hostPush, hostPop;
    logic [7:0] fifoByte;
    scsiDmaPkg::fifoWord_u pushWord;
    scsiDmaPkg::fifoWord_u popWord;

    // Chip data bus, CPU writes or FIFO bytes
    assign scsiData_o = cpu2s ? cpuWData_i : (f2s ? fifoByte : 8'h00);
    assign cpuData_o  = s2cpu ? scsiData_i : 8'h00;

    scsiSequencer i_seq (
        .CLK135 (CLK135), .AS_ (AS_),
        .cpuReq_i (cpuReq_i), .cpuStrobe_i (cpuStrobe_i), .cpuRw_i (cpuRw_i),
        .dmaDir_i (hostDir_i), .dreqN_i (dreqN_i),
        .fifoFull_i (fifoFull), .fifoEmpty_i (fifoEmpty), .boEq3_i (boEq3),
        .incFifo_i (incFifo), .decFifo_i (decFifo),
        .scsiCs_o (scsiCs_o), .scsiRe_o (scsiRe_o), .scsiWe_o (scsiWe_o),
        .scsiDack_o (scsiDack_o), .lByteN_o (lByteN_o),
        .incBo_o (incBo), .incNi_o (incNi), .incNo_o (incNo),
        .s2f_o (s2f), .f2s_o (f2s), .cpu2s_o (cpu2s), .s2cpu_o (s2cpu),
        .fifoIncReq_o (fifoIncReq), .fifoDecReq_o (fifoDecReq), .ls2Cpu_o (ls2Cpu_o)
    );

    dmaFifo i_fifo (
        .CLK135 (CLK135), .AS_ (AS_),
        .scsiByte_i (scsiData_i), .lByte_i (!lByteN_o && s2f),
        .incBo_i (incBo), .incNi_i (incNi), .incNo_i (incNo),
        .hostPush_i (hostPush), .hostPop_i (hostPop), .hostWord_i (pushWord),
        .incFifo_i (incFifo), .decFifo_i (decFifo),
        .scsiByte_o (fifoByte), .hostWord_o (popWord), .boEq3_o (boEq3),
        .full_o (fifoFull), .empty_o (fifoEmpty)
    );

    hostBusFsm i_host (
        .CLK135 (CLK135), .AS_ (AS_),
        .hostWrite_i (hostWrite_i), .hostRead_i (hostRead_i), .hostWData_i (hostWData_i),
        .fifoIncReq_i (fifoIncReq), .fifoDecReq_i (fifoDecReq),
        .fifoFull_i (fifoFull), .fifoEmpty_i (fifoEmpty), .fifoWord_i (popWord),
        .hostPush_o (hostPush), .hostPop_o (hostPop), .fifoWord_o (pushWord),
        .incFifo_o (incFifo), .decFifo_o (decFifo),
        .hostRData_o (hostRData_o), .hostRValid_o (hostRValid_o),
        .hostFull_o (hostFull_o), .hostEmpty_o (hostEmpty_o)
    );

endmodule

//--- bench/scsiChipModel.sv
// Behavioral SCSI chip
`timescale 1ns/1ps

module scsiChipModel (
    input  logic       CLK135,
    input  logic [3:0] regAddr_i,           // Register select, not part of the DUT
    input  logic       cs_i,
    input  logic       re_i,
    input  logic       we_i,
    input  logic       dack_i,
    input  logic [7:0] data_i,              // Bus driven by the DUT
    input  logic       xferStart_i,         // Load a new DMA length
    input  logic [6:0] xferLen_i,
    output logic [7:0] data_o,              // Bus driven by the chip
    output logic       dreqN_o              // DMA request, active low
);

    logic [7:0] regFile [16];
    logic [7:0] srcBytes [64];              // Bytes offered to the DUT
    logic [7:0] rxBytes [64];               // Bytes taken from the DUT
    logic [6:0] xferLen;
    logic [6:0] startCnt;                   // Bytes whose DACK has begun
    logic [6:0] doneCnt;                    // Bytes whose DACK has ended
    logic [6:0] rxCnt;
    logic       dackQ;
    int         i;

    initial begin
        for (i = 0; i < 16; i++) begin
            regFile[i] = {i[3:0], ~i[3:0]}; // Pattern from the full address
        end
        xferLen  = '0;
        startCnt = '0;
        doneCnt  = '0;
        rxCnt    = '0;
        dackQ    = 1'b0;
    end

    // Request drops already during the DACK of the last byte
    assign dreqN_o = !((xferLen - startCnt) > (dack_i ? 7'd1 : 7'd0));

    // Byte stays on the bus until its DACK ends
    assign data_o = (cs_i && re_i) ? regFile[regAddr_i] : srcBytes[doneCnt[5:0]];

    always @(posedge CLK135) begin
        dackQ <= dack_i;
        if (xferStart_i) begin
            xferLen  <= xferLen_i;
            startCnt <= '0;
            doneCnt  <= '0;
            rxCnt    <= '0;
        end else begin
            if (dack_i && !dackQ) startCnt <= startCnt + 1'b1;
            if (!dack_i && dackQ) doneCnt  <= doneCnt + 1'b1;
            if (dack_i && !dackQ && we_i) begin   // Sink samples the first DACK cycle
                rxBytes[rxCnt[5:0]] <= data_i;
                rxCnt               <= rxCnt + 1'b1;
            end
        end
        if (cs_i && we_i) regFile[regAddr_i] <= data_i; // CPU register write
    end

endmodule

//--- bench/scsiDmaTb.sv
// SCSI DMA testbench
`timescale 1ns/1ps

module scsiDmaTb;

    localparam int waitLimit     = 400;     // Cycles per wait
    localparam int untilAckLow   = 0;
    localparam int untilAckHigh  = 1;
    localparam int untilCsLow    = 2;
    localparam int untilNotEmpty = 3;
    localparam int untilEmpty    = 4;
    localparam int untilNotFull  = 5;
    localparam int untilFull     = 6;
    localparam int untilRValid   = 7;
    localparam int untilRxCount  = 8;
    localparam int untilDack     = 9;

    logic        CLK135 = 1'b0;
    logic        AS_;
    logic        cpuReq_i, cpuStrobe_i, cpuRw_i, hostDir_i, dreqN;
    logic        hostWrite_i, hostRead_i;
    logic [7:0]  cpuWData_i, chipData;
    logic [31:0] hostWData_i;
    logic        ls2Cpu_o, scsiCs_o, scsiRe_o, scsiWe_o, scsiDack_o, lByteN_o;
    logic        hostFull_o, hostEmpty_o, hostRValid_o;
    logic [7:0]  cpuData_o, scsiData_o;
    logic [31:0] hostRData_o;
    logic [3:0]  regAddr;
    logic        xferStart;
    logic [6:0]  xferLen;
    logic [31:0] lcgState;
    logic [7:0]  srcCopy [64];              // Expected bytes
    int          errors, checks, tests, testErrBase, expectCount;

    always #2 CLK135 = !CLK135;             // 4 ns period

    scsiDmaTop i_dut (
        .CLK135 (CLK135), .AS_ (AS_),
        .cpuReq_i (cpuReq_i), .cpuStrobe_i (cpuStrobe_i), .cpuRw_i (cpuRw_i),
        .cpuWData_i (cpuWData_i), .hostDir_i (hostDir_i), .dreqN_i (dreqN),
        .scsiData_i (chipData), .hostWrite_i (hostWrite_i), .hostWData_i (hostWData_i),
        .hostRead_i (hostRead_i), .ls2Cpu_o (ls2Cpu_o), .cpuData_o (cpuData_o),
        .scsiCs_o (scsiCs_o), .scsiRe_o (scsiRe_o), .scsiWe_o (scsiWe_o),
        .scsiDack_o (scsiDack_o), .lByteN_o (lByteN_o), .scsiData_o (scsiData_o),
        .hostFull_o (hostFull_o), .hostEmpty_o (hostEmpty_o),
        .hostRData_o (hostRData_o), .hostRValid_o (hostRValid_o)
    );

    scsiChipModel i_chip (
        .CLK135 (CLK135), .regAddr_i (regAddr), .cs_i (scsiCs_o), .re_i (scsiRe_o),
        .we_i (scsiWe_o), .dack_i (scsiDack_o), .data_i (scsiData_o),
        .xferStart_i (xferStart), .xferLen_i (xferLen), .data_o (chipData), .dreqN_o (dreqN)
    );

    function automatic logic [7:0] randByte();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:24];             // Upper bits have the longest period
    endfunction

    task automatic tick();
        @(posedge CLK135);
        #0.5;                               // Drive and sample just after the edge
    endtask

    task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s got %02h expected %02h", name, got, exp);
        end
    endtask

    task automatic checkWord(input string name, input scsiDmaPkg::fifoWord_u got,
                             input scsiDmaPkg::fifoWord_u exp);
        checks++;
        if (got.longWord !== exp.longWord) begin
            errors++;
            $display("Error %s got %08h expected %08h", name, got.longWord, exp.longWord);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s got %01h expected %01h", name, got, exp);
        end
    endtask

    task automatic failTimeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Finished with errors");
        $finish;
    endtask

    function automatic logic condMet(input int sel);
        case (sel)
            untilAckLow:   return !ls2Cpu_o;
            untilAckHigh:  return ls2Cpu_o;
            untilCsLow:    return !scsiCs_o;
            untilNotEmpty: return !hostEmpty_o;
            untilEmpty:    return hostEmpty_o;
            untilNotFull:  return !hostFull_o;
            untilFull:     return hostFull_o;
            untilRValid:   return hostRValid_o;
            untilDack:     return scsiDack_o;
            default:       return i_chip.rxCnt == expectCount;
        endcase
    endfunction

    task automatic waitFor(input int sel, input string what);
        int n;
        n = 0;
        while (condMet(sel) !== 1'b1 && n < waitLimit) begin
            tick();
            n++;
        end
        if (condMet(sel) !== 1'b1) failTimeout(what);
    endtask

    task automatic finishTest(input string name);
        tests++;
        $display("Test %s done, %0d errors", name, errors - testErrBase);
        testErrBase = errors;
    endtask

    task automatic runCpuCycle(input logic rw, input logic [7:0] wData, output logic [7:0] rData);
        cpuReq_i    = 1'b1;
        cpuStrobe_i = 1'b1;
        cpuRw_i     = rw;
        cpuWData_i  = wData;
        waitFor(untilAckLow, "ls2Cpu_o to fall");
        rData = cpuData_o;                  // Latched while termination is low
        tick();
        checkFlag("ls2Cpu_o", ls2Cpu_o, 1'b0); // Held while the strobe stays
        cpuStrobe_i = 1'b0;
        cpuReq_i    = 1'b0;
        waitFor(untilAckHigh, "ls2Cpu_o to rise");
        waitFor(untilCsLow, "scsiCs_o to drop");
    endtask

    task automatic startChip(input int len);
        xferLen   = len[6:0];
        xferStart = 1'b1;
        tick();
        xferStart = 1'b0;
    endtask

    task automatic readHostWord(output scsiDmaPkg::fifoWord_u word);
        waitFor(untilNotEmpty, "hostEmpty_o to fall");
        hostRead_i = 1'b1;
        tick();
        hostRead_i = 1'b0;
        waitFor(untilRValid, "hostRValid_o");
        word.longWord = hostRData_o;
    endtask

    task automatic writeHostWord(input logic [31:0] data);
        waitFor(untilNotFull, "hostFull_o to fall");
        hostWData_i = data;
        hostWrite_i = 1'b1;
        tick();
        hostWrite_i = 1'b0;
    endtask

    task automatic loadChipBytes(input int len);
        int i;
        for (i = 0; i < len; i++) begin
            srcCopy[i]         = randByte();
            i_chip.srcBytes[i] = srcCopy[i];
        end
    endtask

    task automatic readAndCheckWords(input int num);
        scsiDmaPkg::fifoWord_u got, exp;
        int w;
        for (w = 0; w < num; w++) begin
            readHostWord(got);
            exp.longWord = {srcCopy[4*w], srcCopy[4*w+1], srcCopy[4*w+2], srcCopy[4*w+3]};
            checkWord("hostRData_o", got, exp);
        end
    endtask

    task automatic testReset();
        AS_ = 1'b1;
        repeat (2) tick();
        AS_ = 1'b0;
        tick();
        checkFlag("scsiCs_o", scsiCs_o, 1'b0);
        checkFlag("scsiRe_o", scsiRe_o, 1'b0);
        checkFlag("scsiWe_o", scsiWe_o, 1'b0);
        checkFlag("scsiDack_o", scsiDack_o, 1'b0);
        checkFlag("lByteN_o", lByteN_o, 1'b1);
        checkFlag("ls2Cpu_o", ls2Cpu_o, 1'b1);
        checkFlag("hostEmpty_o", hostEmpty_o, 1'b1);
        checkFlag("hostFull_o", hostFull_o, 1'b0);
        finishTest("reset");
    endtask

    task automatic testCpuWrite();
        logic [7:0] wData, rData;
        wData   = randByte();
        regAddr = 4'h3;
        runCpuCycle(1'b0, wData, rData);
        checkByte("regFile[3]", i_chip.regFile[3], wData);
        finishTest("cpu write");
    endtask

    task automatic testCpuRead();
        logic [7:0] rData;
        regAddr = 4'h9;
        runCpuCycle(1'b1, 8'h00, rData);
        checkByte("cpuData_o", rData, {regAddr, ~regAddr}); // Chip preload rule
        finishTest("cpu read");
    endtask

    task automatic testScsiToHost();
        hostDir_i = 1'b0;
        loadChipBytes(8);
        startChip(8);
        waitFor(untilDack, "scsiDack_o to rise");
        checkFlag("lByteN_o", lByteN_o, 1'b0); // Byte load while DACK and RE are high
        readAndCheckWords(2);
        tick();
        checkFlag("hostEmpty_o", hostEmpty_o, 1'b1);
        finishTest("scsi to host");
    endtask

    task automatic testHostToScsi();
        logic [31:0] words [2];
        int w, j;
        hostDir_i = 1'b1;
        startChip(8);
        for (w = 0; w < 2; w++) begin
            for (j = 0; j < 4; j++) words[w] = {words[w][23:0], randByte()};
            writeHostWord(words[w]);
        end
        expectCount = 8;
        waitFor(untilRxCount, "eight bytes at the chip");
        for (w = 0; w < 8; w++) begin       // Big-endian byte order on the wire
            checkByte("rxBytes", i_chip.rxBytes[w], words[w/4][31-8*(w%4) -: 8]);
        end
        waitFor(untilEmpty, "hostEmpty_o to rise");
        finishTest("host to scsi");
    endtask

    task automatic testBackPressure();
        hostDir_i = 1'b0;
        loadChipBytes(40);
        startChip(40);
        waitFor(untilFull, "hostFull_o to rise");
        repeat (16) begin                   // No byte may move while full
            tick();
            checkFlag("scsiDack_o", scsiDack_o, 1'b0);
        end
        checkByte("startCnt", {1'b0, i_chip.startCnt}, 8'd32);
        readAndCheckWords(10);
        checkByte("startCnt", {1'b0, i_chip.startCnt}, 8'd40);
        tick();
        checkFlag("hostEmpty_o", hostEmpty_o, 1'b1);
        finishTest("back-pressure");
    endtask

    initial begin
        AS_         = 1'b1;
        cpuReq_i    = 1'b0;
        cpuStrobe_i = 1'b0;
        cpuRw_i     = 1'b0;
        cpuWData_i  = 8'h00;
        hostDir_i   = 1'b0;
        hostWrite_i = 1'b0;
        hostRead_i  = 1'b0;
        hostWData_i = '0;
        regAddr     = 4'h0;
        xferStart   = 1'b0;
        xferLen     = '0;
        lcgState    = 32'h99fa0a5c;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        testErrBase = 0;
        expectCount = 0;
        testReset();
        testCpuWrite();
        testCpuRead();
        testScsiToHost();
        testHostToScsi();
        testBackPressure();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- build.f
hdl/scsiDmaPkg.sv
hdl/scsiTransferFsm.sv
hdl/scsiSequencer.sv
hdl/dmaFifo.sv
hdl/hostBusFsm.sv
hdl/scsiDmaTop.sv
bench/scsiChipModel.sv
bench/scsiDmaTb.sv

//--- Bender.yml
package:
  name: scsi_dma

sources:
  - hdl/scsiDmaPkg.sv
  - hdl/scsiTransferFsm.sv
  - hdl/scsiSequencer.sv
  - hdl/dmaFifo.sv
  - hdl/hostBusFsm.sv
  - hdl/scsiDmaTop.sv
  - target: simulation
    files:
      - bench/scsiChipModel.sv
      - bench/scsiDmaTb.sv
